/* xike_pkg.sv */
package xike_pkg;

  // Tag layout, stream above channel
  localparam int STREAM_W = 3;
  localparam int CH_W     = 6;
  localparam int TAG_W    = STREAM_W + CH_W;

  // Raw Intan samples and their signed form
  localparam int SAMPLE_W = 16;
  localparam int RAW_W    = SAMPLE_W + 1;

  // Signed filter result carried in the host word
  localparam int MUA_W = 23;

  // One filter history per distinct tag
  localparam int NUM_KEYS = 1 << TAG_W;

  // Queue depths
  localparam int BUNDLE_FIFO_DEPTH = 16;
  localparam int MUA_FIFO_DEPTH    = 16;

  typedef logic [TAG_W-1:0] tag_t;

  typedef logic signed [RAW_W-1:0] raw_t;

  typedef logic signed [MUA_W-1:0] mua_t;

  // Sample as it leaves the intake FIFO
  typedef struct packed {
    tag_t tag;
    raw_t raw;
  } sample_bundle_t;

  // Word seen by the host, tag in the top 9 bits
  typedef struct packed {
    tag_t tag;
    mua_t value;
  } mua_word_t;

  // Band-pass taps
  localparam int FIR_TAPS = 4;

  // Index 0 weighs the current sample, higher indices older ones
  localparam mua_t FIR_COEFS [FIR_TAPS] = '{
    mua_t'(1),
    mua_t'(1),
    mua_t'(-1),
    mua_t'(-1)
  };

endpackage

/* fwft_fifo.sv */
`timescale 1ns/1ps

module fwft_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     bus_clk,
  input  logic     rst_n,
  input  logic     wr_en,
  input  payload_t wr_data,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     full,
  output logic     empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_wr;
  logic          do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // Head word is always visible
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: count <= count;
      endcase
    end
  end

  a_no_write_when_full: assert property (
    @(posedge bus_clk) disable iff (!rst_n) !(wr_en && full)
  ) else $error("fwft_fifo written while full");

  a_no_read_when_empty: assert property (
    @(posedge bus_clk) disable iff (!rst_n) !(rd_en && empty)
  ) else $error("fwft_fifo read while empty");

endmodule

/* sample_intake.sv */
`timescale 1ns/1ps

module sample_intake import xike_pkg::*; (
  input  logic                bus_clk,
  input  logic                rst_n,
  input  logic                sample_wen,
  input  logic [STREAM_W-1:0] sample_stream,
  input  logic [CH_W-1:0]     sample_ch,
  input  logic [SAMPLE_W-1:0] sample_data,
  output logic                bundle_valid,
  input  logic                bundle_ready,
  output sample_bundle_t      bundle,
  output logic                fifo_overflow
);

  sample_bundle_t new_bundle;
  logic           fifo_full;
  logic           fifo_empty;

  // Unsigned Intan data becomes a non-negative 17-bit signed value
  assign new_bundle.tag = {sample_stream, sample_ch};
  assign new_bundle.raw = raw_t'({1'b0, sample_data});

  assign bundle_valid = !fifo_empty;

  fwft_fifo #(
    .payload_t (sample_bundle_t),
    .DEPTH     (BUNDLE_FIFO_DEPTH)
  ) u_bundle_fifo (
    .bus_clk (bus_clk),
    .rst_n   (rst_n),
    .wr_en   (sample_wen && !fifo_full),
    .wr_data (new_bundle),
    .rd_en   (bundle_valid && bundle_ready),
    .rd_data (bundle),
    .full    (fifo_full),
    .empty   (fifo_empty)
  );

  // Sticky until reset
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_overflow <= 1'b0;
    end else if (sample_wen && fifo_full) begin
      fifo_overflow <= 1'b1;
    end
  end

  // Filter may stall, the offered bundle must not change under it
  a_bundle_held: assert property (
    @(posedge bus_clk) disable iff (!rst_n)
    bundle_valid && !bundle_ready |=> bundle_valid && $stable(bundle)
  ) else $error("bundle changed before transfer");

endmodule

/* fir_bandpass.sv */
`timescale 1ns/1ps

module fir_bandpass import xike_pkg::*; (
  input  logic           bus_clk,
  input  logic           rst_n,
  input  logic           bundle_valid,
  output logic           bundle_ready,
  input  sample_bundle_t bundle,
  output logic           mua_valid,
  input  logic           mua_ready,
  output tag_t           mua_tag,
  output mua_t           mua_value
);

  // Older samples of one key, newest at index 0
  typedef raw_t [FIR_TAPS-2:0] hist_t;

  hist_t               hist_mem [NUM_KEYS];
  logic [NUM_KEYS-1:0] seen;

  logic  stall;
  logic  accept;
  logic  s1_adv;

  logic  s1_valid;
  tag_t  s1_tag;
  raw_t  s1_raw;
  hist_t s1_hist;

  hist_t rd_hist;
  hist_t wb_hist;
  raw_t  taps [FIR_TAPS];
  mua_t  fir_sum;

  // Host back-pressure freezes the whole pipe
  assign stall        = !mua_ready;
  assign bundle_ready = !stall;
  assign accept       = bundle_valid && bundle_ready;
  assign s1_adv       = s1_valid && !stall;

  // History after the stage-1 sample is shifted in
  assign wb_hist = {s1_hist[FIR_TAPS-3:0], s1_raw};

  // Stage-1 read, with forwarding from the write-back of the same key
  always_comb begin
    if (s1_valid && (s1_tag == bundle.tag)) begin
      rd_hist = wb_hist;
    end else if (seen[bundle.tag]) begin
      rd_hist = hist_mem[bundle.tag];
    end else begin
      rd_hist = '0;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= bundle_valid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (accept) begin
      s1_tag  <= bundle.tag;
      s1_raw  <= bundle.raw;
      s1_hist <= rd_hist;
    end
  end

  // Stage 2 weighted sum
  always_comb begin
    taps[0] = s1_raw;
    for (int i = 1; i < FIR_TAPS; i++) begin
      taps[i] = s1_hist[i-1];
    end
    fir_sum = '0;
    for (int i = 0; i < FIR_TAPS; i++) begin
      fir_sum = fir_sum + FIR_COEFS[i] * mua_t'(taps[i]);
    end
  end

  always_ff @(posedge bus_clk) begin
    if (s1_adv) begin
      hist_mem[s1_tag] <= wb_hist;
    end
  end

  // Unseen keys read as an all-zero history
  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      seen <= '0;
    end else if (s1_adv) begin
      seen[s1_tag] <= 1'b1;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      mua_valid <= 1'b0;
    end else if (!stall) begin
      mua_valid <= s1_valid;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (s1_adv) begin
      mua_tag   <= s1_tag;
      mua_value <= fir_sum;
    end
  end

  a_mua_held: assert property (
    @(posedge bus_clk) disable iff (!rst_n)
    mua_valid && !mua_ready |=> mua_valid && $stable(mua_tag) && $stable(mua_value)
  ) else $error("MUA output changed while stalled");

endmodule

/* mua_readout.sv */
`timescale 1ns/1ps

module mua_readout import xike_pkg::*; (
  input  logic      bus_clk,
  input  logic      rst_n,
  input  logic      mua_valid,
  output logic      mua_ready,
  input  tag_t      mua_tag,
  input  mua_t      mua_value,
  input  logic      mua_rden,
  output mua_word_t mua_data,
  output logic      mua_empty
);

  mua_word_t host_word;
  logic      fifo_full;

  assign host_word.tag   = mua_tag;
  assign host_word.value = mua_value;

  // Ready drops only while the host queue is full
  assign mua_ready = !fifo_full;

  fwft_fifo #(
    .payload_t (mua_word_t),
    .DEPTH     (MUA_FIFO_DEPTH)
  ) u_host_fifo (
    .bus_clk (bus_clk),
    .rst_n   (rst_n),
    .wr_en   (mua_valid && mua_ready),
    .wr_data (host_word),
    .rd_en   (mua_rden),
    .rd_data (mua_data),
    .full    (fifo_full),
    .empty   (mua_empty)
  );

  a_host_read_empty: assert property (
    @(posedge bus_clk) disable iff (!rst_n) mua_rden |-> !mua_empty
  ) else $error("host read the MUA queue while empty");

endmodule

/* xike_top.sv */
`timescale 1ns/1ps

module xike_top import xike_pkg::*; (
  input  logic                bus_clk,
  input  logic                rst_n,
  input  logic                sample_wen,
  input  logic [STREAM_W-1:0] sample_stream,
  input  logic [CH_W-1:0]     sample_ch,
  input  logic [SAMPLE_W-1:0] sample_data,
  input  logic                mua_rden,
  output mua_word_t           mua_data,
  output logic                mua_empty,
  output logic                fifo_overflow
);

  logic           bundle_valid;
  logic           bundle_ready;
  sample_bundle_t bundle;

  logic           mua_valid;
  logic           mua_ready;
  tag_t           mua_tag;
  mua_t           mua_value;

  sample_intake u_intake (
    .bus_clk       (bus_clk),
    .rst_n         (rst_n),
    .sample_wen    (sample_wen),
    .sample_stream (sample_stream),
    .sample_ch     (sample_ch),
    .sample_data   (sample_data),
    .bundle_valid  (bundle_valid),
    .bundle_ready  (bundle_ready),
    .bundle        (bundle),
    .fifo_overflow (fifo_overflow)
  );

  fir_bandpass u_fir (
    .bus_clk      (bus_clk),
    .rst_n        (rst_n),
    .bundle_valid (bundle_valid),
    .bundle_ready (bundle_ready),
    .bundle       (bundle),
    .mua_valid    (mua_valid),
    .mua_ready    (mua_ready),
    .mua_tag      (mua_tag),
    .mua_value    (mua_value)
  );

  mua_readout u_readout (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .mua_valid (mua_valid),
    .mua_ready (mua_ready),
    .mua_tag   (mua_tag),
    .mua_value (mua_value),
    .mua_rden  (mua_rden),
    .mua_data  (mua_data),
    .mua_empty (mua_empty)
  );

endmodule

/* tb_xike.sv */
`timescale 1ns/1ps

module tb_xike import xike_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int N_RANDOM     = 300;
  localparam int N_PAIR       = 200;
  localparam int N_HOLD       = BUNDLE_FIFO_DEPTH + MUA_FIFO_DEPTH - 1;
  localparam int N_BURST      = 64;
  localparam int PAUSE_CYCLES = 10;
  localparam int QUIET_CYCLES = 8;
  // Both FIFOs plus the two filter stages
  localparam int KEPT_SAMPLES = BUNDLE_FIFO_DEPTH + MUA_FIFO_DEPTH + 2;
  localparam int DRAIN_CYCLES = KEPT_SAMPLES + QUIET_CYCLES + 8;
  localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + N_RANDOM + N_PAIR + N_HOLD
                                   + N_BURST + 2 * PAUSE_CYCLES + 4 * DRAIN_CYCLES + 100;

  logic                bus_clk;
  logic                rst_n;
  logic                sample_wen;
  logic [STREAM_W-1:0] sample_stream;
  logic [CH_W-1:0]     sample_ch;
  logic [SAMPLE_W-1:0] sample_data;
  logic                mua_rden;
  mua_word_t           mua_data;
  logic                mua_empty;
  logic                fifo_overflow;

  integer    seed;
  logic      host_reading;
  string     test_name;
  int        words_read;
  // Model history per tag, index 0 is the newest sample
  int        hist [NUM_KEYS][FIR_TAPS];
  mua_word_t expected [$];

  xike_top dut (
    .bus_clk       (bus_clk),
    .rst_n         (rst_n),
    .sample_wen    (sample_wen),
    .sample_stream (sample_stream),
    .sample_ch     (sample_ch),
    .sample_data   (sample_data),
    .mua_rden      (mua_rden),
    .mua_data      (mua_data),
    .mua_empty     (mua_empty),
    .fifo_overflow (fifo_overflow)
  );

  initial begin
    bus_clk = 1'b0;
    forever #50 bus_clk = ~bus_clk;
  end

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_mua(input string name, input mua_word_t exp, input mua_word_t act);
    if (act !== exp) begin
      $display("Error: %s expected %h (tag %0d value %0d) actual %h (tag %0d value %0d)",
               name, exp, exp.tag, exp.value, act, act.tag, act.value);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error: %s expected %0d actual %0d", name, exp, act);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  task automatic clear_model();
    for (int k = 0; k < NUM_KEYS; k++) begin
      for (int i = 0; i < FIR_TAPS; i++) begin
        hist[k][i] = 0;
      end
    end
    expected.delete();
  endtask

  // Shift the sample into its tag history and queue the filter result
  task automatic predict_sample(input tag_t tag, input logic [SAMPLE_W-1:0] data);
    int        acc;
    mua_word_t word;
    for (int i = FIR_TAPS - 1; i > 0; i--) begin
      hist[tag][i] = hist[tag][i-1];
    end
    hist[tag][0] = int'(data);
    acc = 0;
    for (int i = 0; i < FIR_TAPS; i++) begin
      acc = acc + int'(FIR_COEFS[i]) * hist[tag][i];
    end
    word.tag   = tag;
    word.value = mua_t'(acc);
    expected.push_back(word);
  endtask

  task automatic take_word();
    mua_word_t exp_word;
    if (expected.size() == 0) begin
      $display("Host word %h showed up in %s with no sample waiting for it",
               mua_data, test_name);
      stop_with_failure();
    end
    exp_word = expected.pop_front();
    check_mua(test_name, exp_word, mua_data);
    words_read++;
  endtask

  // One clock of host read and sample strobe, driven on the falling edge
  task automatic run_cycle(input logic wr, input tag_t tag, input logic [SAMPLE_W-1:0] data);
    @(negedge bus_clk);
    if (host_reading && !mua_empty) begin
      take_word();
      mua_rden = 1'b1;
    end else begin
      mua_rden = 1'b0;
    end
    sample_wen    = wr;
    sample_stream = tag[TAG_W-1:CH_W];
    sample_ch     = tag[CH_W-1:0];
    sample_data   = data;
    if (wr) begin
      predict_sample(tag, data);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) run_cycle(1'b0, tag_t'(0), 16'h0000);
  endtask

  // Read until the host queue has stayed empty for a while
  task automatic drain_to_quiet();
    int quiet;
    quiet = 0;
    host_reading = 1'b1;
    while (quiet < QUIET_CYCLES) begin
      run_cycle(1'b0, tag_t'(0), 16'h0000);
      if (mua_empty) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  task automatic apply_reset();
    @(negedge bus_clk);
    rst_n        = 1'b0;
    sample_wen   = 1'b0;
    mua_rden     = 1'b0;
    host_reading = 1'b0;
    repeat (RESET_CYCLES) @(negedge bus_clk);
    rst_n = 1'b1;
    clear_model();
    check_flag("reset_mua_empty", 1'b1, mua_empty);
    check_flag("reset_fifo_overflow", 1'b0, fifo_overflow);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge bus_clk);
    $display("Watchdog expired after %0d cycles, the run appears to hang", WATCHDOG_CYCLES);
    stop_with_failure();
  end

  initial begin
    logic [31:0] rnd;
    tag_t        pair [2];
    rst_n         = 1'b0;
    sample_wen    = 1'b0;
    sample_stream = '0;
    sample_ch     = '0;
    sample_data   = '0;
    mua_rden      = 1'b0;
    host_reading  = 1'b0;
    seed          = 32'h7efe;
    words_read    = 0;
    test_name     = "reset";
    apply_reset();

    // Random tags, strobes on about half the cycles
    test_name    = "random_tags";
    host_reading = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd = next_random();
      run_cycle(rnd[31], rnd[24:16], rnd[15:0]);
    end
    drain_to_quiet();
    check_count("random_tags_left", 0, expected.size());

    // Back-to-back strobes over two tags exercise forwarding
    test_name = "two_tags";
    rnd       = next_random();
    pair[0]   = rnd[8:0];
    pair[1]   = ~rnd[8:0];
    for (int n = 0; n < N_PAIR; n++) begin
      rnd = next_random();
      run_cycle(1'b1, pair[rnd[20]], rnd[15:0]);
    end
    drain_to_quiet();
    check_count("two_tags_left", 0, expected.size());
    check_flag("two_tags_overflow", 1'b0, fifo_overflow);

    // Host paused while the queues absorb the samples
    test_name    = "host_stall";
    host_reading = 1'b0;
    for (int n = 0; n < N_HOLD; n++) begin
      rnd = next_random();
      run_cycle(1'b1, rnd[24:16], rnd[15:0]);
    end
    idle_cycles(PAUSE_CYCLES);
    check_flag("host_stall_overflow", 1'b0, fifo_overflow);
    drain_to_quiet();
    check_count("host_stall_left", 0, expected.size());
    check_flag("host_stall_overflow_end", 1'b0, fifo_overflow);

    // Burst past capacity with the host paused
    apply_reset();
    test_name  = "overflow";
    words_read = 0;
    for (int n = 0; n < N_BURST; n++) begin
      rnd = next_random();
      run_cycle(1'b1, rnd[24:16], rnd[15:0]);
    end
    idle_cycles(PAUSE_CYCLES);
    check_flag("overflow_set", 1'b1, fifo_overflow);
    drain_to_quiet();
    check_flag("overflow_sticky", 1'b1, fifo_overflow);
    check_count("overflow_words_read", KEPT_SAMPLES, words_read);
    check_count("overflow_words_dropped", N_BURST - KEPT_SAMPLES, expected.size());
    expected.delete();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* verilog.f */
xike_pkg.sv
fwft_fifo.sv
sample_intake.sv
fir_bandpass.sv
mua_readout.sv
xike_top.sv
tb_xike.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the xike testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_xike -f verilog.f \
  --Mdir obj_dir -o tb_xike
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_xike
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

exit 0
